// File: verification/cpuPatterns.mem
// Hex words, one per address, counting on from the last @ marker
// Program at 00, initial data at 80, expected results from A0
@00
// ALU, immediates and forwarding
6000 4105 46FD F6C0 FC1C FDC1 FCC6 FC85
F81C F887 F844 55F0 6312 FDC3 FE82 F41C
FC1C F81C
// Store, load, load-use on ADD and on WWD
5080 8302 7102 F580 F81C 7301 FC1C 8203
// r0 = DEAD, wrong-path slots hold WWD r0
60DE 50AD
// BNE taken, BEQ untaken
0602 F01C F01C 1602 4F01 FC1C
// BEQ taken
1F02 F01C F01C
// BGZ untaken, BLZ taken
F445 2402 F41C 3402 F01C F01C
// BGZ taken
2C02 F01C F01C
// BLZ untaken, BNE untaken
3C02 0F02 F81C
// JMP to 34
9034 F01C F01C
// WWD, HLT, nothing after it may show
FC1C F01D F01C F01C F01C
@80
// Initial data words
1111 00A5 0000 0000
@A0
// WWD value count, then the values in order
000B
0007 FFFC 00F1 12F1 12F0 25E2 00A5 00A6
ED0F 25E2 00A6
// Memory check count, then address and word pairs
0003
0080 1111
0082 12F1
0083 25E2
// Retired instructions through HLT
002C

// File: vlog.f
+incdir+source
source/cpuPkg.sv
source/fetchStage.sv
source/decodeStage.sv
source/hazardUnit.sv
source/executeStage.sv
source/haltControl.sv
source/retireCounter.sv
source/cpuTop.sv
verification/cpuTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Builds the CPU testbench with Verilator, runs it, checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module cpuTb \
    -o cpuSim > build.log 2>&1 &&
./obj_dir/cpuSim > sim.log 2>&1 ||
{ echo "Build or run error, see build.log and sim.log"; exit 1; }
grep -qx "Simulation passed" sim.log &&
echo "PASS" ||
{ echo "FAIL, see sim.log"; exit 1; }

// File: verification/cpuTb.sv
/* CPU testbench with clock, reset and a combinational memory model
   WWD capture, result checks against the pattern file, watchdog and report */
`timescale 1ns/100ps
`include "cpu_settings.svh"

module cpuTb;
    import cpuPkg::*;

    localparam int clkPeriod   = 4;
    localparam int resetCycles = 4;
    localparam int progWords   = 128;
    localparam int expBase     = 160;
    // HLT reaches WB and the count settles
    localparam int drainCycles = 4;
    // Eight cycles per program word on top of reset
    localparam int watchdogNs  = (resetCycles + 8 * progWords) * clkPeriod;

    logic    Clk;
    logic    i_rst;
    logic    instRead;
    cpuWordT instAddr;
    cpuWordT instData;
    logic    dataRead;
    logic    dataWrite;
    cpuWordT dataAddr;
    cpuWordT dataWdata;
    cpuWordT dataRdata;
    cpuWordT outPort;
    logic    outValid;
    logic    halted;
    cpuWordT retired;

    // Program, data and expected results share one image
    cpuWordT mem [2**`CPU_MEM_AW];

    cpuWordT expOut [$];
    cpuWordT expAddr [$];
    cpuWordT expData [$];
    cpuWordT expRetired;
    cpuWordT outSeen [$];

    int      errors;
    int      testsRun;
    int      testsFailed;
    int      lateOutputs;
    int      lateFetches;
    int      missedFetches;
    logic    haltSeen;
    logic    haltDropped;

    // Both memories answer in the same cycle
    assign instData  = mem[instAddr[`CPU_MEM_AW-1:0]];
    assign dataRdata = mem[dataAddr[`CPU_MEM_AW-1:0]];

    cpuTop i_dut (
        .Clk         (Clk),
        .i_rst       (i_rst),
        .o_instRead  (instRead),
        .o_instAddr  (instAddr),
        .i_instData  (instData),
        .o_dataRead  (dataRead),
        .o_dataWrite (dataWrite),
        .o_dataAddr  (dataAddr),
        .o_dataWdata (dataWdata),
        .i_dataRdata (dataRdata),
        .o_outPort   (outPort),
        .o_outValid  (outValid),
        .o_halted    (halted),
        .o_retired   (retired)
    );

    initial begin
        Clk = 1'b0;
        forever #(clkPeriod / 2) Clk = ~Clk;
    end

    //////////////////////////////
    // Falling-edge monitor
    //////////////////////////////
    always @(negedge Clk) begin
        if (!i_rst) begin
            // Store lands mid-cycle so a later load sees it
            if (dataWrite) begin
                mem[dataAddr[`CPU_MEM_AW-1:0]] = dataWdata;
            end
            if (outValid) begin
                if (halted) begin
                    lateOutputs++;
                end else begin
                    outSeen.push_back(outPort);
                end
                // A WWD in EX means the CPU is still running
                if (!instRead) begin
                    missedFetches++;
                end
            end
            if (halted && instRead) begin
                lateFetches++;
            end
            if (haltSeen && !halted) begin
                haltDropped = 1'b1;
            end
            if (halted) begin
                haltSeen = 1'b1;
            end
        end
    end

    //////////////////////////////
    // Checks and report
    //////////////////////////////
    task automatic checkOutValue(input string name, input cpuWordT expVal,
                                 input cpuWordT actVal);
        if (actVal !== expVal) begin
            $display("FAILED %s: expected %h, actual %h", name, expVal, actVal);
            errors++;
        end
    endtask

    task automatic checkMemWord(input string name, input cpuWordT expVal,
                                input cpuWordT actVal);
        if (actVal !== expVal) begin
            $display("FAILED %s: expected %h, actual %h", name, expVal, actVal);
            errors++;
        end
    endtask

    task automatic checkRetired(input string name, input cpuWordT expVal,
                                input cpuWordT actVal);
        if (actVal !== expVal) begin
            $display("FAILED %s: expected %0d, actual %0d", name, expVal, actVal);
            errors++;
        end
    endtask

    task automatic finishTest(input string name, input int errBefore);
        testsRun++;
        if (errors == errBefore) begin
            $display("Test %s: ok", name);
        end else begin
            testsFailed++;
            $display("Test %s: %0d check(s) wrong", name, errors - errBefore);
        end
    endtask

    // Count, WWD values, count, address and word pairs, retire count
    task automatic loadExpected();
        int idx;
        int n;
        idx = expBase;
        n   = mem[idx];
        idx++;
        for (int k = 0; k < n; k++) begin
            expOut.push_back(mem[idx]);
            idx++;
        end
        n = mem[idx];
        idx++;
        for (int k = 0; k < n; k++) begin
            expAddr.push_back(mem[idx]);
            expData.push_back(mem[idx + 1]);
            idx += 2;
        end
        expRetired = mem[idx];
    endtask

    initial begin
        int errBefore;
        i_rst         = 1'b1;
        errors        = 0;
        testsRun      = 0;
        testsFailed   = 0;
        lateOutputs   = 0;
        lateFetches   = 0;
        missedFetches = 0;
        haltSeen      = 1'b0;
        haltDropped   = 1'b0;
        $readmemh("verification/cpuPatterns.mem", mem);
        loadExpected();

        repeat (resetCycles) @(negedge Clk);
        errBefore = errors;
        if (instRead || outValid || halted || dataRead || dataWrite) begin
            $display("Status or memory strobes not low at the end of reset");
            errors++;
        end
        checkRetired("resetRetired", '0, retired);
        finishTest("resetState", errBefore);
        i_rst = 1'b0;

        // Run until HLT, then let the pipeline drain
        while (!halted) @(negedge Clk);
        repeat (drainCycles) @(negedge Clk);
        #(clkPeriod / 4);

        errBefore = errors;
        if (outSeen.size() != expOut.size()) begin
            $display("WWD gave %0d values where %0d were expected",
                     outSeen.size(), expOut.size());
            errors++;
        end
        for (int k = 0; k < expOut.size() && k < outSeen.size(); k++) begin
            checkOutValue($sformatf("wwd[%0d]", k), expOut[k], outSeen[k]);
        end
        finishTest("wwdSequence", errBefore);

        errBefore = errors;
        for (int k = 0; k < expAddr.size(); k++) begin
            checkMemWord($sformatf("mem[%h]", expAddr[k]), expData[k],
                         mem[expAddr[k][`CPU_MEM_AW-1:0]]);
        end
        finishTest("dataMemory", errBefore);

        errBefore = errors;
        if (haltDropped) begin
            $display("Halted output fell after it had risen");
            errors++;
        end
        if (lateOutputs != 0) begin
            $display("WWD output appeared %0d time(s) after halt", lateOutputs);
            errors++;
        end
        finishTest("haltHold", errBefore);

        errBefore = errors;
        if (missedFetches != 0) begin
            $display("Instruction fetch strobe was low %0d time(s) while running",
                     missedFetches);
            errors++;
        end
        if (lateFetches != 0) begin
            $display("Instruction fetch strobe was high %0d time(s) after halt",
                     lateFetches);
            errors++;
        end
        finishTest("fetchStrobe", errBefore);

        errBefore = errors;
        checkRetired("retired", expRetired, retired);
        finishTest("retireCount", errBefore);

        $display("Tests run %0d, tests failed %0d, checks failed %0d",
                 testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog in case HLT is never reached
    initial begin
        #(watchdogNs);
        $display("Timeout, the CPU did not halt within %0d ns", watchdogNs);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: source/cpuTop.sv
/* Five-stage CPU top level
   Stage, hazard, halt and retire instances */
`timescale 1ns/100ps

module cpuTop (
    input  logic            Clk,
    input  logic            i_rst,
    // Instruction memory
    output logic            o_instRead,
    output cpuPkg::cpuWordT o_instAddr,
    input  cpuPkg::cpuWordT i_instData,
    // Data memory
    output logic            o_dataRead,
    output logic            o_dataWrite,
    output cpuPkg::cpuWordT o_dataAddr,
    output cpuPkg::cpuWordT o_dataWdata,
    input  cpuPkg::cpuWordT i_dataRdata,
    // WWD port and status
    output cpuPkg::cpuWordT o_outPort,
    output logic            o_outValid,
    output logic            o_halted,
    output cpuPkg::cpuWordT o_retired
);
    import cpuPkg::*;

    // Stage registers
    ifIdS    ifId;
    idExS    idEx;
    exMemS   exMem;
    memWbS   wb;

    // Hazard handshake between ID and the hazard unit
    regIdxT  srcA;
    regIdxT  srcB;
    logic    useA;
    logic    useB;
    fwdSelE  fwdA;
    fwdSelE  fwdB;
    logic    stall;

    // Redirects and forwarded values
    logic    brRedirect;
    cpuWordT brTarget;
    logic    jmpRedirect;
    cpuWordT jmpTarget;
    cpuWordT exResult;
    cpuWordT memResult;

    // Run control and retirement
    logic    run;
    logic    haltReq;
    logic    retire;

    fetchStage uFetch (
        .Clk, .i_rst, .i_run(run), .i_stall(stall),
        .i_brRedirect(brRedirect), .i_brTarget(brTarget),
        .i_jmpRedirect(jmpRedirect), .i_jmpTarget(jmpTarget),
        .i_instData, .o_instRead, .o_instAddr, .o_ifId(ifId)
    );

    decodeStage uDecode (
        .Clk, .i_rst, .i_ifId(ifId), .i_stall(stall), .i_brFlush(brRedirect),
        .i_fwdA(fwdA), .i_fwdB(fwdB), .i_exResult(exResult),
        .i_memResult(memResult), .i_wb(wb),
        .o_srcA(srcA), .o_srcB(srcB), .o_useA(useA), .o_useB(useB),
        .o_jmpRedirect(jmpRedirect), .o_jmpTarget(jmpTarget), .o_idEx(idEx)
    );

    hazardUnit uHazard (
        .i_srcA(srcA), .i_srcB(srcB), .i_useA(useA), .i_useB(useB),
        .i_idEx(idEx), .i_exMem(exMem), .i_wb(wb),
        .o_fwdA(fwdA), .o_fwdB(fwdB), .o_stall(stall)
    );

    executeStage uExecute (
        .Clk, .i_rst, .i_idEx(idEx), .o_exResult(exResult), .o_exMem(exMem),
        .o_memResult(memResult), .o_brRedirect(brRedirect), .o_brTarget(brTarget),
        .o_dataRead, .o_dataWrite, .o_dataAddr, .o_dataWdata, .i_dataRdata,
        .o_wb(wb), .o_outPort, .o_outValid, .o_retire(retire), .o_haltReq(haltReq)
    );

    haltControl uHalt (
        .Clk, .i_rst, .i_haltReq(haltReq), .o_run(run), .o_halted
    );

    retireCounter uRetire (
        .Clk, .i_rst, .i_retire(retire), .o_count(o_retired)
    );

endmodule

// File: source/retireCounter.sv
/* Saturating count of retired instructions */
`timescale 1ns/100ps

module retireCounter (
    input  logic            Clk,
    input  logic            i_rst,
    input  logic            i_retire,
    output cpuPkg::cpuWordT o_count
);
    always_ff @(posedge Clk) begin
        if (i_rst) begin
            o_count <= '0;
        end else if (i_retire && o_count != '1) begin
            // Sticks at all ones
            o_count <= o_count + 1'b1;
        end
    end

endmodule

// File: source/haltControl.sv
/* Run/halt FSM that stops fetch for good after HLT */
`timescale 1ns/100ps

module haltControl (
    input  logic Clk,
    input  logic i_rst,
    input  logic i_haltReq,
    output logic o_run,
    output logic o_halted
);
    typedef enum logic {
        stRunning,
        stHalted
    } stateE;

    stateE state;

    always_ff @(posedge Clk) begin
        if (i_rst) begin
            state <= stRunning;
        end else begin
            case (state)
                stRunning: begin
                    if (i_haltReq) begin
                        state <= stHalted;
                    end
                end
                // Only reset leaves Halted
                default: state <= stHalted;
            endcase
        end
    end

    // Fetch freezes already in the HLT cycle
    assign o_run    = state == stRunning && !i_haltReq;
    assign o_halted = state == stHalted;

    // Pipeline is drained once halted so no HLT reaches EX again
    assert property (@(posedge Clk) disable iff (i_rst)
        o_halted |-> !i_haltReq);

endmodule

// File: source/executeStage.sv
/* Execute, memory and writeback stages
   ALU, branch resolve, EX/MEM and MEM/WB registers */
`timescale 1ns/100ps

module executeStage (
    input  logic            Clk,
    input  logic            i_rst,
    input  cpuPkg::idExS    i_idEx,
    output cpuPkg::cpuWordT o_exResult,
    output cpuPkg::exMemS   o_exMem,
    output cpuPkg::cpuWordT o_memResult,
    output logic            o_brRedirect,
    output cpuPkg::cpuWordT o_brTarget,
    output logic            o_dataRead,
    output logic            o_dataWrite,
    output cpuPkg::cpuWordT o_dataAddr,
    output cpuPkg::cpuWordT o_dataWdata,
    input  cpuPkg::cpuWordT i_dataRdata,
    output cpuPkg::memWbS   o_wb,
    output cpuPkg::cpuWordT o_outPort,
    output logic            o_outValid,
    output logic            o_retire,
    output logic            o_haltReq
);
    import cpuPkg::*;

    cpuWordT aluB;
    cpuWordT aluResult;
    logic    taken;

    ////////////////////////////////
    // EX
    ////////////////////////////////
    assign aluB = i_idEx.ctrl.useImm ? i_idEx.imm : i_idEx.opB;

    always_comb begin
        unique case (i_idEx.ctrl.aluOp)
            aluSub:  aluResult = i_idEx.opA - aluB;
            aluAnd:  aluResult = i_idEx.opA & aluB;
            aluOr:   aluResult = i_idEx.opA | aluB;
            aluNot:  aluResult = ~i_idEx.opA;
            aluTcp:  aluResult = ~i_idEx.opA + 1'b1;
            aluShl:  aluResult = i_idEx.opA << 1;
            // Arithmetic, sign bit kept
            aluShr:  aluResult = cpuWordT'($signed(i_idEx.opA) >>> 1);
            aluLhi:  aluResult = {aluB[7:0], 8'h00};
            default: aluResult = i_idEx.opA + aluB;
        endcase
    end

    // BNE/BEQ compare rs and rt, BGZ/BLZ test rs alone
    always_comb begin
        case (i_idEx.ctrl.opcode)
            opBne:   taken = i_idEx.opA != i_idEx.opB;
            opBeq:   taken = i_idEx.opA == i_idEx.opB;
            opBgz:   taken = $signed(i_idEx.opA) > 0;
            opBlz:   taken = $signed(i_idEx.opA) < 0;
            default: taken = 1'b0;
        endcase
    end

    // HLT squashes the younger slots just like a taken branch
    assign o_brRedirect = i_idEx.valid &&
                          ((i_idEx.ctrl.isBranch && taken) || i_idEx.ctrl.isHalt);
    assign o_brTarget   = i_idEx.pc + 1'b1 + i_idEx.imm;
    assign o_exResult   = aluResult;

    // WWD shows rs while in EX
    assign o_outPort  = i_idEx.opA;
    assign o_outValid = i_idEx.valid && i_idEx.ctrl.isWwd;
    assign o_haltReq  = i_idEx.valid && i_idEx.ctrl.isHalt;

    always_ff @(posedge Clk) begin
        if (i_rst) begin
            o_exMem.valid <= 1'b0;
        end else begin
            o_exMem.valid <= i_idEx.valid;
        end
        o_exMem.aluResult <= aluResult;
        o_exMem.storeData <= i_idEx.opB;
        o_exMem.ctrl      <= i_idEx.ctrl;
    end

    ////////////////////////////////
    // MEM and WB
    ////////////////////////////////
    assign o_dataRead  = o_exMem.valid && o_exMem.ctrl.memRead;
    assign o_dataWrite = o_exMem.valid && o_exMem.ctrl.memWrite;
    assign o_dataAddr  = o_exMem.aluResult;
    assign o_dataWdata = o_exMem.storeData;
    // Also the MEM forwarding value
    assign o_memResult = o_exMem.ctrl.memToReg ? i_dataRdata : o_exMem.aluResult;

    always_ff @(posedge Clk) begin
        if (i_rst) begin
            o_wb.valid <= 1'b0;
        end else begin
            o_wb.valid <= o_exMem.valid;
        end
        o_wb.result   <= o_memResult;
        o_wb.destReg  <= o_exMem.ctrl.destReg;
        o_wb.regWrite <= o_exMem.ctrl.regWrite;
    end

    // Every live entry leaving WB retires
    assign o_retire = o_wb.valid;

endmodule

// File: source/hazardUnit.sv
/* Forwarding source select and load-use stall */
`timescale 1ns/100ps

module hazardUnit (
    input  cpuPkg::regIdxT i_srcA,
    input  cpuPkg::regIdxT i_srcB,
    input  logic           i_useA,
    input  logic           i_useB,
    input  cpuPkg::idExS   i_idEx,
    input  cpuPkg::exMemS  i_exMem,
    input  cpuPkg::memWbS  i_wb,
    output cpuPkg::fwdSelE o_fwdA,
    output cpuPkg::fwdSelE o_fwdB,
    output logic           o_stall
);
    import cpuPkg::*;

    // Youngest valid writer of src or else the register file
    function automatic fwdSelE pickSource(regIdxT src);
        if (i_idEx.valid && i_idEx.ctrl.regWrite && i_idEx.ctrl.destReg == src) begin
            return fwdEx;
        end
        if (i_exMem.valid && i_exMem.ctrl.regWrite && i_exMem.ctrl.destReg == src) begin
            return fwdMem;
        end
        if (i_wb.valid && i_wb.regWrite && i_wb.destReg == src) begin
            return fwdWb;
        end
        return fwdRf;
    endfunction

    always_comb begin
        o_fwdA = pickSource(i_srcA);
        o_fwdB = pickSource(i_srcB);
    end

    // Load data is not ready until MEM so hold one cycle
    assign o_stall = i_idEx.ctrl.memRead &&
                     ((i_useA && o_fwdA == fwdEx) || (i_useB && o_fwdB == fwdEx));

endmodule

// File: source/decodeStage.sv
/* Decode stage: controls, register file,
   operand forwarding, JMP and the ID/EX register */
`timescale 1ns/100ps
`include "cpu_settings.svh"

module decodeStage (
    input  logic            Clk,
    input  logic            i_rst,
    input  cpuPkg::ifIdS    i_ifId,
    input  logic            i_stall,
    input  logic            i_brFlush,
    input  cpuPkg::fwdSelE  i_fwdA,
    input  cpuPkg::fwdSelE  i_fwdB,
    input  cpuPkg::cpuWordT i_exResult,
    input  cpuPkg::cpuWordT i_memResult,
    input  cpuPkg::memWbS   i_wb,
    output cpuPkg::regIdxT  o_srcA,
    output cpuPkg::regIdxT  o_srcB,
    output logic            o_useA,
    output logic            o_useB,
    output logic            o_jmpRedirect,
    output cpuPkg::cpuWordT o_jmpTarget,
    output cpuPkg::idExS    o_idEx
);
    import cpuPkg::*;

    cpuWordT regFile [`CPU_REG_CNT];
    instrU   instr;
    ctrlS    ctrl;
    cpuWordT imm;
    cpuWordT opA;
    cpuWordT opB;
    logic    useA;
    logic    useB;

    // Register value or a younger in-flight result
    function automatic cpuWordT pickOperand(fwdSelE sel, cpuWordT rfVal);
        case (sel)
            fwdEx:   return i_exResult;
            fwdMem:  return i_memResult;
            fwdWb:   return i_wb.result;
            default: return rfVal;
        endcase
    endfunction

    assign instr  = i_ifId.instr;
    assign o_srcA = instr.r.rs;
    assign o_srcB = instr.r.rt;
    assign o_useA = i_ifId.valid && useA;
    assign o_useB = i_ifId.valid && useB;

    // ORI zero-extends, everything else sign-extends
    assign imm = (instr.i.opcode == opOri) ? {8'h00, instr.i.imm}
                                           : {{8{instr.i.imm[7]}}, instr.i.imm};

    ////////////////////////////////
    // Control decode
    ////////////////////////////////
    always_comb begin
        ctrl         = '0;
        ctrl.aluOp   = aluAdd;
        ctrl.opcode  = instr.r.opcode;
        // I-type writes rt
        ctrl.destReg = instr.i.rt;
        useA         = 1'b1;
        useB         = 1'b0;
        unique case (instr.r.opcode)
            opAdi: begin
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            opOri: begin
                ctrl.aluOp    = aluOr;
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            opLhi: begin
                ctrl.aluOp    = aluLhi;
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
                useA          = 1'b0;
            end
            opLwd: begin
                ctrl.useImm   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            opSwd: begin
                // Address from rs+imm, data from rt
                ctrl.useImm   = 1'b1;
                ctrl.memWrite = 1'b1;
                useB          = 1'b1;
            end
            opBne, opBeq: begin
                ctrl.isBranch = 1'b1;
                useB          = 1'b1;
            end
            opBgz, opBlz: ctrl.isBranch = 1'b1;
            opR: begin
                ctrl.destReg = instr.r.rd;
                unique case (instr.r.func)
                    fnAdd, fnSub, fnAnd, fnOrr, fnNot, fnTcp, fnShl, fnShr: begin
                        ctrl.aluOp    = aluOpE'(instr.r.func[3:0]);
                        ctrl.regWrite = 1'b1;
                        // Unary ops read rs only
                        useB          = !instr.r.func[2];
                    end
                    fnWwd: ctrl.isWwd = 1'b1;
                    fnHlt: begin
                        ctrl.isHalt = 1'b1;
                        useA        = 1'b0;
                    end
                    default: useA = 1'b0;
                endcase
            end
            // JMP and unknown opcodes read nothing
            default: useA = 1'b0;
        endcase
    end

    ////////////////////////////////
    // Register file and operands
    ////////////////////////////////
    always_ff @(posedge Clk) begin
        if (i_wb.valid && i_wb.regWrite) begin
            regFile[i_wb.destReg] <= i_wb.result;
        end
    end

    always_comb begin
        opA = pickOperand(i_fwdA, regFile[instr.r.rs]);
        opB = pickOperand(i_fwdB, regFile[instr.r.rt]);
    end

    // JMP keeps the PC page, resolved here
    assign o_jmpRedirect = i_ifId.valid && instr.j.opcode == opJmp;
    assign o_jmpTarget   = {i_ifId.pc[15:12], instr.j.target};

    // ID/EX, bubble on branch flush or load-use stall
    always_ff @(posedge Clk) begin
        if (i_rst || i_brFlush || i_stall) begin
            o_idEx.valid <= 1'b0;
        end else begin
            o_idEx.valid <= i_ifId.valid;
        end
        o_idEx.pc   <= i_ifId.pc;
        o_idEx.opA  <= opA;
        o_idEx.opB  <= opB;
        o_idEx.imm  <= imm;
        o_idEx.ctrl <= ctrl;
    end

endmodule

// File: source/fetchStage.sv
/* Fetch stage
   PC, next-PC priority and the IF/ID register */
`timescale 1ns/100ps

module fetchStage (
    input  logic            Clk,
    input  logic            i_rst,
    input  logic            i_run,
    input  logic            i_stall,
    input  logic            i_brRedirect,
    input  cpuPkg::cpuWordT i_brTarget,
    input  logic            i_jmpRedirect,
    input  cpuPkg::cpuWordT i_jmpTarget,
    input  cpuPkg::cpuWordT i_instData,
    output logic            o_instRead,
    output cpuPkg::cpuWordT o_instAddr,
    output cpuPkg::ifIdS    o_ifId
);
    import cpuPkg::*;

    cpuWordT pc;

    // Memory answers in the same cycle
    assign o_instAddr = pc;
    // No fetch strobe while held in reset
    assign o_instRead = i_run && !i_rst;

    ////////////////////////////////
    // PC and IF/ID
    ////////////////////////////////
    // Priority order is halt, EX branch, ID jump, stall, PC+1
    always_ff @(posedge Clk) begin
        if (i_rst) begin
            pc           <= '0;
            o_ifId.valid <= 1'b0;
        end else if (!i_run) begin
            // Frozen so nothing new enters
            o_ifId.valid <= 1'b0;
        end else if (i_brRedirect) begin
            pc           <= i_brTarget;
            o_ifId.valid <= 1'b0;
        end else if (i_jmpRedirect) begin
            pc           <= i_jmpTarget;
            o_ifId.valid <= 1'b0;
        end else if (!i_stall) begin
            pc           <= pc + 1'b1;
            o_ifId.valid <= 1'b1;
            o_ifId.pc    <= pc;
            o_ifId.instr <= i_instData;
        end
    end

    // A load-use stall never meets a taken branch or jump
    assert property (@(posedge Clk) disable iff (i_rst)
        i_stall |-> !(i_brRedirect || i_jmpRedirect));

endmodule

// File: source/cpuPkg.sv
/* ISA encodings, the instruction word union,
   decoded controls and pipeline register structs */
`include "cpu_settings.svh"

package cpuPkg;

    typedef logic [`CPU_WORD_W-1:0] cpuWordT;
    typedef logic [1:0]             regIdxT;

    // Primary opcodes, all R-type share 15
    typedef enum logic [3:0] {
        opBne = 4'd0, opBeq = 4'd1, opBgz = 4'd2, opBlz = 4'd3,
        opAdi = 4'd4, opOri = 4'd5, opLhi = 4'd6,
        opLwd = 4'd7, opSwd = 4'd8, opJmp = 4'd9,
        opR   = 4'd15
    } opcodeE;

    // R-type function field
    typedef enum logic [5:0] {
        fnAdd = 6'd0, fnSub = 6'd1, fnAnd = 6'd2, fnOrr = 6'd3,
        fnNot = 6'd4, fnTcp = 6'd5, fnShl = 6'd6, fnShr = 6'd7,
        fnWwd = 6'd28, fnHlt = 6'd29
    } funcE;

    // One fetched word, three ways to read it
    typedef union packed {
        struct packed {
            opcodeE opcode;
            regIdxT rs;
            regIdxT rt;
            regIdxT rd;
            funcE   func;
        } r;
        struct packed {
            opcodeE     opcode;
            regIdxT     rs;
            regIdxT     rt;
            logic [7:0] imm;
        } i;
        struct packed {
            opcodeE      opcode;
            logic [11:0] target;
        } j;
    } instrU;

    // Low eight follow the R-type function codes
    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluNot, aluTcp, aluShl, aluShr,
        aluLhi
    } aluOpE;

    typedef struct packed {
        aluOpE  aluOp;
        logic   useImm;
        logic   memRead;
        logic   memWrite;
        logic   regWrite;
        logic   memToReg;
        logic   isBranch;
        logic   isWwd;
        logic   isHalt;
        regIdxT destReg;
        // Branch kind for EX
        opcodeE opcode;
    } ctrlS;

    ////////////////////////////////
    // Pipeline registers
    ////////////////////////////////
    typedef struct packed {
        logic    valid;
        cpuWordT pc;
        instrU   instr;
    } ifIdS;

    typedef struct packed {
        logic    valid;
        cpuWordT pc;
        cpuWordT opA;
        cpuWordT opB;
        cpuWordT imm;
        ctrlS    ctrl;
    } idExS;

    typedef struct packed {
        logic    valid;
        cpuWordT aluResult;
        cpuWordT storeData;
        ctrlS    ctrl;
    } exMemS;

    typedef struct packed {
        logic    valid;
        cpuWordT result;
        regIdxT  destReg;
        logic    regWrite;
    } memWbS;

    // Operand source, youngest producer wins
    typedef enum logic [1:0] {
        fwdRf, fwdEx, fwdMem, fwdWb
    } fwdSelE;

endpackage

// File: source/cpu_settings.svh
/* Word width, register count and memory
   address width of the 16-bit pipelined CPU */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data and address word
`define CPU_WORD_W 16

// Architectural registers r0..r3
`define CPU_REG_CNT 4

// Modeled memory depth as an address width
`define CPU_MEM_AW 8

`endif
